/* include/rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// First fetch address after reset
`define RV_RESET_ADDR 32'h8000_0000

// Data path width
`define RV_XLEN 32

// Register index width, 32 architectural registers
`define RV_REG_AW 5

// ADDI x0, x0, 0
// Fills squashed or reset pipeline slots
`define RV_NOP 32'h0000_0013

`endif

/* rtl/rv_core_pkg.sv */
`include "rv_core_config.svh"

package rv_core_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        STORE  = 7'b0100011
    } opcode_e;

    // Encoded as {branch, alt funct, funct3}
    typedef enum logic [4:0] {
        ALU_ADD  = 5'b00000,
        ALU_SLL  = 5'b00001,
        ALU_SLT  = 5'b00010,
        ALU_SLTU = 5'b00011,
        ALU_XOR  = 5'b00100,
        ALU_SRL  = 5'b00101,
        ALU_OR   = 5'b00110,
        ALU_AND  = 5'b00111,
        ALU_SUB  = 5'b01000,
        ALU_SRA  = 5'b01101,
        ALU_BEQ  = 5'b10000,
        ALU_BNE  = 5'b10001,
        ALU_BLT  = 5'b10100,
        ALU_BGE  = 5'b10101,
        ALU_BLTU = 5'b10110,
        ALU_BGEU = 5'b10111
    } alu_op_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        opcode_e               opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        opcode_e               opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        opcode_e               opcode;
    } s_fmt_t;

    // Branch offset bits scattered as in the ISA
    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        opcode_e               opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [`RV_REG_AW-1:0] rd;
        opcode_e               opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
    } instr_u;

    typedef struct packed {
        logic [31:0]           pc;
        logic [`RV_XLEN-1:0]   rs1_data;
        logic [`RV_XLEN-1:0]   rs2_data;
        logic [`RV_XLEN-1:0]   imm;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        alu_op_e               alu_op;
        logic                  use_pc_zero;  // Operand A forced to zero (LUI)
        logic                  use_imm;
        logic                  is_branch;
        logic                  is_store;
        logic                  reg_we;
    } id_ex_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   result;
        logic [`RV_XLEN-1:0]   store_data;
        logic [`RV_REG_AW-1:0] rd;
        logic                  reg_we;
        logic                  is_store;
    } ex_mem_t;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
        logic                  we;
    } wb_fwd_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } redirect_t;

endpackage

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`RV_REG_AW-1:0] rs1_i,
    input  logic [`RV_REG_AW-1:0] rs2_i,
    input  rv_core_pkg::wb_fwd_t  wr_i,
    output logic [`RV_XLEN-1:0]   rs1_data_o,
    output logic [`RV_XLEN-1:0]   rs2_data_o
);

    localparam int NREGS = 2 ** `RV_REG_AW;

    logic [`RV_XLEN-1:0] regs [NREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && wr_i.rd != '0) begin
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    // No write-through here, execute picks up the same-cycle write
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* rtl/rv_alu.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_alu (
    input  rv_core_pkg::alu_op_e op_i,
    input  logic [`RV_XLEN-1:0]  a_i,
    input  logic [`RV_XLEN-1:0]  b_i,
    output logic [`RV_XLEN-1:0]  result_o
);

    localparam int XLEN = `RV_XLEN;

    logic       eq;
    logic       lt_s;
    logic       lt_u;
    logic [4:0] shamt;

    assign eq    = (a_i == b_i);
    assign lt_s  = ($signed(a_i) < $signed(b_i));
    assign lt_u  = (a_i < b_i);
    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            rv_core_pkg::ALU_ADD:  result_o = a_i + b_i;
            rv_core_pkg::ALU_SUB:  result_o = a_i - b_i;
            rv_core_pkg::ALU_SLL:  result_o = a_i << shamt;
            rv_core_pkg::ALU_SLT:  result_o = XLEN'(lt_s);
            rv_core_pkg::ALU_SLTU: result_o = XLEN'(lt_u);
            rv_core_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            rv_core_pkg::ALU_SRL:  result_o = a_i >> shamt;
            rv_core_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            rv_core_pkg::ALU_OR:   result_o = a_i | b_i;
            rv_core_pkg::ALU_AND:  result_o = a_i & b_i;
            // Branch ops give 1 when the branch is taken
            rv_core_pkg::ALU_BEQ:  result_o = XLEN'(eq);
            rv_core_pkg::ALU_BNE:  result_o = XLEN'(!eq);
            rv_core_pkg::ALU_BLT:  result_o = XLEN'(lt_s);
            rv_core_pkg::ALU_BGE:  result_o = XLEN'(!lt_s);
            rv_core_pkg::ALU_BLTU: result_o = XLEN'(lt_u);
            rv_core_pkg::ALU_BGEU: result_o = XLEN'(!lt_u);
            default:               result_o = '0;  // Reserved R-type encodings
        endcase
    end

endmodule

/* rtl/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [31:0]            instr_data_i,
    input  logic                   instr_ready_i,
    input  logic                   stall_i,
    input  rv_core_pkg::redirect_t redirect_i,
    output logic [31:0]            instr_addr_o,
    output rv_core_pkg::instr_u    if_instr_o,
    output logic [31:0]            if_pc_o
);

    logic [31:0] pc_q;
    logic        advance;

    // Word counts as fetched only on a ready edge with no store pending
    assign advance      = instr_ready_i && !stall_i;
    assign instr_addr_o = pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q       <= `RV_RESET_ADDR;
            if_instr_o <= `RV_NOP;
            if_pc_o    <= `RV_RESET_ADDR;
        end else if (advance) begin
            if (redirect_i.taken) begin
                // Word fetched this cycle is on the wrong path
                pc_q       <= redirect_i.target;
                if_instr_o <= `RV_NOP;
                if_pc_o    <= redirect_i.target;
            end else begin
                pc_q       <= pc_q + 32'd4;
                if_instr_o <= instr_data_i;
                if_pc_o    <= pc_q;
            end
        end
    end

endmodule

/* rtl/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_core_pkg::instr_u  instr_i,
    input  logic [31:0]          pc_i,
    input  logic                 instr_ready_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    input  rv_core_pkg::wb_fwd_t wr_i,
    output rv_core_pkg::id_ex_t  id_ex_o
);

    rv_core_pkg::id_ex_t id_ex_d;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic                advance;

    assign advance = instr_ready_i && !stall_i;

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_i      (instr_i.r_fmt.rs1),
        .rs2_i      (instr_i.r_fmt.rs2),
        .wr_i       (wr_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    always_comb begin
        id_ex_d          = '0;
        id_ex_d.pc       = pc_i;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.rs1      = instr_i.r_fmt.rs1;
        id_ex_d.rs2      = instr_i.r_fmt.rs2;
        id_ex_d.rd       = instr_i.r_fmt.rd;
        id_ex_d.alu_op   = rv_core_pkg::ALU_ADD;  // Address and LUI path
        case (instr_i.r_fmt.opcode)
            rv_core_pkg::OP: begin
                id_ex_d.alu_op = rv_core_pkg::alu_op_e'({1'b0, instr_i.r_fmt.funct7[5],
                                                         instr_i.r_fmt.funct3});
                id_ex_d.reg_we = 1'b1;
            end
            rv_core_pkg::OP_IMM: begin
                // Bit 30 selects SRAI, elsewhere it is part of the immediate
                id_ex_d.alu_op  = rv_core_pkg::alu_op_e'({1'b0,
                    (instr_i.i_fmt.funct3 == 3'b101) && instr_i.r_fmt.funct7[5],
                    instr_i.i_fmt.funct3});
                id_ex_d.imm     = {{20{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
                id_ex_d.use_imm = 1'b1;
                id_ex_d.reg_we  = 1'b1;
            end
            rv_core_pkg::LUI: begin
                id_ex_d.imm         = {instr_i.u_fmt.imm, 12'b0};
                id_ex_d.use_pc_zero = 1'b1;
                id_ex_d.use_imm     = 1'b1;
                id_ex_d.reg_we      = 1'b1;
            end
            rv_core_pkg::BRANCH: begin
                id_ex_d.alu_op    = rv_core_pkg::alu_op_e'({2'b10, instr_i.b_fmt.funct3});
                id_ex_d.imm       = {{20{instr_i.b_fmt.imm12}}, instr_i.b_fmt.imm11,
                                     instr_i.b_fmt.imm10_5, instr_i.b_fmt.imm4_1, 1'b0};
                id_ex_d.is_branch = 1'b1;
            end
            rv_core_pkg::STORE: begin
                id_ex_d.imm      = {{20{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_hi,
                                    instr_i.s_fmt.imm_lo};
                id_ex_d.use_imm  = 1'b1;
                id_ex_d.is_store = 1'b1;
            end
            default: begin
                // Unsupported words pass through as bubbles
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_o <= '0;
        end else if (advance) begin
            id_ex_o <= flush_i ? '0 : id_ex_d;  // Squash behind a taken branch
        end
    end

endmodule

/* rtl/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_execute (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_core_pkg::id_ex_t    id_ex_i,
    input  logic                   instr_ready_i,
    input  logic                   stall_i,
    input  rv_core_pkg::wb_fwd_t   fwd_mem_i,
    input  rv_core_pkg::wb_fwd_t   fwd_wb_i,
    input  rv_core_pkg::wb_fwd_t   fwd_late_i,
    output rv_core_pkg::ex_mem_t   ex_mem_o,
    output rv_core_pkg::redirect_t redirect_o
);

    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic                advance;

    // Youngest producer wins, x0 is never forwarded
    function automatic logic [`RV_XLEN-1:0] fwd_pick(
        input logic [`RV_REG_AW-1:0] rs,
        input logic [`RV_XLEN-1:0]   reg_val,
        input rv_core_pkg::wb_fwd_t  src_mem,
        input rv_core_pkg::wb_fwd_t  src_wb,
        input rv_core_pkg::wb_fwd_t  src_late
    );
        if (rs == '0)
            return reg_val;
        if (src_mem.we && src_mem.rd == rs)
            return src_mem.data;
        if (src_wb.we && src_wb.rd == rs)
            return src_wb.data;
        if (src_late.we && src_late.rd == rs)
            return src_late.data;  // Regfile write landed after decode read
        return reg_val;
    endfunction

    assign advance = instr_ready_i && !stall_i;
    assign rs1_val = fwd_pick(id_ex_i.rs1, id_ex_i.rs1_data, fwd_mem_i, fwd_wb_i, fwd_late_i);
    assign rs2_val = fwd_pick(id_ex_i.rs2, id_ex_i.rs2_data, fwd_mem_i, fwd_wb_i, fwd_late_i);

    assign alu_a = id_ex_i.use_pc_zero ? '0 : rs1_val;
    assign alu_b = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;

    rv_alu u_alu (
        .op_i     (id_ex_i.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    // Also serves as the flush for fetch and decode
    assign redirect_o.taken  = id_ex_i.is_branch && alu_result[0];
    assign redirect_o.target = id_ex_i.pc + id_ex_i.imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_o <= '0;
        end else if (advance) begin
            ex_mem_o.result     <= alu_result;  // Store address for SW
            ex_mem_o.store_data <= rs2_val;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.reg_we     <= id_ex_i.reg_we;
            ex_mem_o.is_store   <= id_ex_i.is_store;
        end
    end

endmodule

/* rtl/rv_mem_stage.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_mem_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_core_pkg::ex_mem_t ex_mem_i,
    input  logic                 mem_ready_i,
    input  logic                 instr_ready_i,
    output logic                 mem_we_o,
    output logic [31:0]          mem_addr_o,
    output logic [`RV_XLEN-1:0]  mem_wdata_o,
    output logic                 stall_o,
    output rv_core_pkg::wb_fwd_t fwd_wb_o,
    output rv_core_pkg::wb_fwd_t fwd_late_o
);

    logic store_done_q;  // Accepted, waiting for fetch to release the pipe
    logic advance;

    assign mem_we_o    = ex_mem_i.is_store && !store_done_q;
    assign mem_addr_o  = ex_mem_i.result;
    assign mem_wdata_o = ex_mem_i.store_data;
    assign stall_o     = mem_we_o && !mem_ready_i;
    assign advance     = instr_ready_i && !stall_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_done_q <= 1'b0;
        end else if (advance) begin
            store_done_q <= 1'b0;
        end else if (mem_we_o && mem_ready_i) begin
            store_done_q <= 1'b1;  // Stops a second write of the same store
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fwd_wb_o   <= '0;
            fwd_late_o <= '0;
        end else if (advance) begin
            fwd_wb_o   <= '{rd: ex_mem_i.rd, data: ex_mem_i.result, we: ex_mem_i.reg_we};
            fwd_late_o <= fwd_wb_o;
        end
    end

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [31:0]         instr_data_i,
    input  logic                instr_ready_i,
    input  logic                mem_ready_i,
    output logic [31:0]         instr_addr_o,
    output logic                mem_we_o,
    output logic [31:0]         mem_addr_o,
    output logic [`RV_XLEN-1:0] mem_wdata_o
);

    rv_core_pkg::instr_u    if_instr;
    logic [31:0]            if_pc;
    rv_core_pkg::id_ex_t    id_ex;
    rv_core_pkg::ex_mem_t   ex_mem;
    rv_core_pkg::redirect_t redirect;
    rv_core_pkg::wb_fwd_t   fwd_mem;
    rv_core_pkg::wb_fwd_t   fwd_wb;
    rv_core_pkg::wb_fwd_t   fwd_late;
    logic                   mem_stall;

    // Execute/memory payload viewed as the first forwarding source
    assign fwd_mem = '{rd: ex_mem.rd, data: ex_mem.result, we: ex_mem.reg_we};

    rv_fetch u_fetch (
        .clk, .rst_n, .instr_data_i, .instr_ready_i,
        .stall_i      (mem_stall),
        .redirect_i   (redirect),
        .instr_addr_o,
        .if_instr_o   (if_instr),
        .if_pc_o      (if_pc)
    );

    rv_decode u_decode (
        .clk, .rst_n, .instr_ready_i,
        .instr_i  (if_instr),
        .pc_i     (if_pc),
        .stall_i  (mem_stall),
        .flush_i  (redirect.taken),
        .wr_i     (fwd_wb),
        .id_ex_o  (id_ex)
    );

    rv_execute u_execute (
        .clk, .rst_n, .instr_ready_i,
        .id_ex_i    (id_ex),
        .stall_i    (mem_stall),
        .fwd_mem_i  (fwd_mem),
        .fwd_wb_i   (fwd_wb),
        .fwd_late_i (fwd_late),
        .ex_mem_o   (ex_mem),
        .redirect_o (redirect)
    );

    rv_mem_stage u_mem_stage (
        .clk, .rst_n, .mem_ready_i, .instr_ready_i,
        .ex_mem_i    (ex_mem),
        .mem_we_o, .mem_addr_o, .mem_wdata_o,
        .stall_o     (mem_stall),
        .fwd_wb_o    (fwd_wb),
        .fwd_late_o  (fwd_late)
    );

endmodule

/* bench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    input  logic rst_req_i,
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset at start, and again on each request
    initial begin
        rst_n = 1'b0;
        forever begin
            repeat (RESET_CYCLES) @(negedge clk);
            rst_n = 1'b1;
            @(posedge rst_req_i);
            @(negedge clk);
            rst_n = 1'b0;
        end
    end

endmodule

/* bench/rv_core_asserts.sv */
`timescale 1ns/1ps

module rv_core_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic        instr_ready_i,
    input logic        mem_ready_i,
    input logic [31:0] instr_addr_o,
    input logic        mem_we_o,
    input logic [31:0] mem_addr_o,
    input logic [31:0] mem_wdata_o
);

    no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !mem_we_o)
        else $error("mem_we_o high during reset");

    // Waiting store keeps its address and data
    store_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we_o && !mem_ready_i |=> mem_we_o && $stable(mem_addr_o) && $stable(mem_wdata_o))
        else $error("store changed while waiting for mem_ready_i");

    fetch_held: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_ready_i |=> $stable(instr_addr_o))
        else $error("instr_addr_o moved while instr_ready_i low");

endmodule

bind rv_core rv_core_asserts u_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_ready_i (instr_ready_i),
    .mem_ready_i   (mem_ready_i),
    .instr_addr_o  (instr_addr_o),
    .mem_we_o      (mem_we_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o)
);

/* bench/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module tb_rv_core;

    localparam int IMEM_WORDS = 256;
    localparam int WAIT_LIMIT = 5000;

    logic        clk;
    logic        rst_n;
    logic        rst_req;
    logic [31:0] instr_data;
    logic        instr_ready;
    logic        mem_ready;
    logic [31:0] instr_addr;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;

    logic [31:0] imem [IMEM_WORDS];
    logic [63:0] seen_q [$];    // {addr, data} of accepted stores
    logic [63:0] expect_q [$];
    int          pc_idx;
    int          slot;
    logic        random_ready;
    logic [31:0] rnd_state;
    int          errors;
    int          checks;
    int          tests;

    tb_clk_gen u_clk_gen (.rst_req_i(rst_req), .clk(clk), .rst_n(rst_n));

    rv_core u_rv_core (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_data_i  (instr_data),
        .instr_ready_i (instr_ready),
        .mem_ready_i   (mem_ready),
        .instr_addr_o  (instr_addr),
        .mem_we_o      (mem_we),
        .mem_addr_o    (mem_addr),
        .mem_wdata_o   (mem_wdata)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    // Branch condition as the ISA defines it
    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Memory models, inputs change on the falling edge
    always @(negedge clk) begin
        if (random_ready) begin
            rnd_state   = xorshift(rnd_state);
            instr_ready = rnd_state[0] | rnd_state[1];
            mem_ready   = rnd_state[7];
        end else begin
            instr_ready = 1'b1;
            mem_ready   = 1'b1;
        end
        instr_data = imem[instr_addr[9:2]];
        #1;
        if (rst_n && mem_we && mem_ready) begin
            seen_q.push_back({mem_addr, mem_wdata});  // Transfers at next rising edge
        end
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        errors++;
    endtask

    task automatic emit(input logic [31:0] w);
        imem[pc_idx] = w;
        pc_idx++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        expect_q.push_back({addr, data});
    endtask

    task automatic start_program;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = i_type(12'(i), 5'd0, 3'b000, 5'd0);  // ADDI x0 with its own index
        end
        pc_idx = 0;
        slot   = 0;
        expect_q.delete();
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800;  // ADDI sign-extends the low part
        emit(lui_word(hi[31:12], rd));
        emit(i_type(value[11:0], rd, 3'b000, rd));
    endtask

    task automatic gap(input int n);
        for (int i = 0; i < n; i++) begin
            emit(`RV_NOP);
        end
    endtask

    // Instruction writes x3, then x3 goes to the next result slot
    task automatic result_store(input logic [31:0] w, input logic [31:0] exp);
        emit(w);
        emit(sw_word(5'd3, 5'd0, 12'(256 + 4 * slot)));
        expect_store(32'(256 + 4 * slot), exp);
        slot++;
    endtask

    task automatic reset_core;
        int n;
        n = 0;
        @(negedge clk);
        rst_req = 1'b1;
        while (rst_n && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (rst_n) begin
            report_failure("reset was not asserted after request");
        end
        rst_req = 1'b0;
        seen_q.delete();
    endtask

    task automatic compare_stores;
        checks++;
        if (seen_q.size() != expect_q.size()) begin
            $display("error at %0t: store count got %0d expected %0d", $time,
                     seen_q.size(), expect_q.size());
            errors++;
        end
        for (int i = 0; i < expect_q.size() && i < seen_q.size(); i++) begin
            checks += 2;
            if (seen_q[i][63:32] != expect_q[i][63:32]) begin
                $display("error at %0t: mem_addr_o store %0d got %h expected %h", $time, i,
                         seen_q[i][63:32], expect_q[i][63:32]);
                errors++;
            end
            if (seen_q[i][31:0] != expect_q[i][31:0]) begin
                $display("error at %0t: mem_wdata_o store %0d got %h expected %h", $time, i,
                         seen_q[i][31:0], expect_q[i][31:0]);
                errors++;
            end
        end
    endtask

    task automatic run_program(input string name);
        int n;
        int errs_before;
        errs_before = errors;
        emit(branch_word(13'd0, 5'd0, 5'd0, 3'b000));  // Spin here when done
        n = 0;
        while (!rst_n && n < 100) begin
            @(negedge clk);
            n++;
        end
        n = 0;
        while (rst_n && seen_q.size() < expect_q.size() && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!rst_n) begin
            report_failure($sformatf("reset did not release in %s", name));
        end else if (seen_q.size() < expect_q.size()) begin
            report_failure($sformatf("timeout in %s, only %0d of %0d stores seen", name,
                                     seen_q.size(), expect_q.size()));
        end else begin
            repeat (30) @(negedge clk);  // Catch stray stores
            compare_stores;
        end
        tests++;
        $display("%s: %s, %0d stores", name, (errors == errs_before) ? "ok" : "failed",
                 seen_q.size());
    endtask

    task automatic alu_test;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        a  = 32'h8765_4321;
        b  = 32'h0000_0013;
        sx = 32'hffff_fffb;  // Immediate -5
        reset_core;
        start_program;
        load_const(5'd1, a);
        load_const(5'd2, b);
        result_store(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), a + b);
        result_store(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), a - b);
        result_store(r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd3), a << b[4:0]);
        result_store(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), 32'($signed(a) < $signed(b)));
        result_store(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd3), 32'(a < b));
        result_store(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), a ^ b);
        result_store(r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd3), a >> b[4:0]);
        result_store(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), $signed(a) >>> b[4:0]);
        result_store(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), a | b);
        result_store(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), a & b);
        result_store(i_type(12'hffb, 5'd1, 3'b000, 5'd3), a + sx);
        result_store(i_type(12'hffb, 5'd1, 3'b010, 5'd3), 32'($signed(a) < $signed(sx)));
        result_store(i_type(12'hffb, 5'd1, 3'b011, 5'd3), 32'(a < sx));
        result_store(i_type(12'hffb, 5'd1, 3'b100, 5'd3), a ^ sx);
        result_store(i_type(12'hffb, 5'd1, 3'b110, 5'd3), a | sx);
        result_store(i_type(12'hffb, 5'd1, 3'b111, 5'd3), a & sx);
        result_store(i_type(12'h007, 5'd1, 3'b001, 5'd3), a << 7);
        result_store(i_type(12'h007, 5'd1, 3'b101, 5'd3), a >> 7);
        result_store(i_type(12'h407, 5'd1, 3'b101, 5'd3), $signed(a) >>> 7);
        result_store(lui_word(20'habcde, 5'd3), 32'habcd_e000);
        run_program("alu");
    endtask

    // Each value used 1, 2 or 3 instructions after it is made
    task automatic build_chain_program;
        logic [31:0] c;
        logic [31:0] addr;
        start_program;
        for (int d = 1; d <= 3; d++) begin
            c    = 32'(37 * d - 60);
            addr = 32'(1024 + 16 * d);
            emit(i_type(c[11:0], 5'd0, 3'b000, 5'd1));
            gap(d - 1);
            emit(i_type(12'h002, 5'd1, 3'b001, 5'd2));
            gap(d - 1);
            emit(r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));
            gap(d - 1);
            emit(sw_word(5'd3, 5'd0, addr[11:0]));
            emit(sw_word(5'd2, 5'd0, addr[11:0] + 12'd4));
            expect_store(addr, c * 3);
            expect_store(addr + 32'd4, c * 4);
        end
    endtask

    task automatic forward_test;
        reset_core;
        build_chain_program;
        run_program("forwarding");
    endtask

    task automatic branch_test;
        logic [2:0]  f3s [6];
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] base;
        logic [31:0] va;
        logic [31:0] vb;
        int          id;
        f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        reset_core;
        start_program;
        emit(i_type(12'hffd, 5'd0, 3'b000, 5'd1));  // x1 = -3
        emit(i_type(12'h005, 5'd0, 3'b000, 5'd2));  // x2 = 5
        id = 0;
        for (int t = 0; t < 6; t++) begin
            for (int p = 0; p < 3; p++) begin
                id++;
                rs1  = (p == 1) ? 5'd2 : 5'd1;
                rs2  = (p == 2) ? 5'd1 : ((p == 1) ? 5'd1 : 5'd2);
                va   = (rs1 == 5'd1) ? 32'hffff_fffd : 32'd5;
                vb   = (rs2 == 5'd1) ? 32'hffff_fffd : 32'd5;
                base = 32'(512 + 16 * id);
                emit(i_type(12'(id), 5'd0, 3'b000, 5'd3));
                emit(branch_word(13'd16, rs2, rs1, f3s[t]));
                for (int s = 0; s < 4; s++) begin
                    emit(sw_word(5'd3, 5'd0, 12'(512 + 16 * id + 4 * s)));
                end
                if (!branch_taken(f3s[t], va, vb)) begin
                    for (int s = 0; s < 3; s++) begin
                        expect_store(base + 32'(4 * s), 32'(id));
                    end
                end
                expect_store(base + 32'd12, 32'(id));  // Branch target
            end
        end
        run_program("branches");
    endtask

    task automatic backpressure_test;
        reset_core;
        random_ready = 1'b1;
        build_chain_program;
        run_program("back-pressure");
        random_ready = 1'b0;
    endtask

    task automatic zero_reg_test;
        reset_core;
        start_program;
        emit(i_type(12'h007, 5'd0, 3'b000, 5'd1));
        emit(i_type(12'h037, 5'd0, 3'b000, 5'd0));
        emit(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        emit(lui_word(20'h12345, 5'd0));
        emit(i_type(12'h001, 5'd0, 3'b000, 5'd4));  // Reads x0 right behind the writes
        emit(sw_word(5'd0, 5'd0, 12'h300));
        emit(sw_word(5'd4, 5'd0, 12'h304));
        emit(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd5));
        emit(sw_word(5'd5, 5'd0, 12'h308));
        expect_store(32'h300, 32'd0);
        expect_store(32'h304, 32'd1);
        expect_store(32'h308, 32'd0);
        run_program("x0");
    endtask

    initial begin
        int n;
        rst_req      = 1'b0;
        instr_data   = `RV_NOP;
        instr_ready  = 1'b1;
        mem_ready    = 1'b1;
        random_ready = 1'b0;
        rnd_state    = 32'hd29f_c2da;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        start_program;
        n = 0;
        while (!rst_n && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!rst_n) begin
            report_failure("initial reset did not release");
        end
        alu_test;
        forward_test;
        branch_test;
        backpressure_test;
        zero_reg_test;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
rtl/rv_core_pkg.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_mem_stage.sv
rtl/rv_core.sv
bench/tb_clk_gen.sv
bench/rv_core_asserts.sv
bench/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
